//--- rtl/room_echo_defines.svh
`ifndef ROOM_ECHO_DEFINES_SVH
`define ROOM_ECHO_DEFINES_SVH

// impulse response length, also sets the tap address width
`define ROOM_ECHO_IR_TAPS 16

// audio_clk cycles per bit clock, 64 bit clocks make one frame
`define ROOM_ECHO_BCLK_DIV 4

// leak of the dc blocker integrator
`define ROOM_ECHO_DC_SHIFT 8

// convolver accumulator, 16 products of 32 bits plus headroom
`define ROOM_ECHO_ACC_W 40

`endif

//--- rtl/room_echo_pkg.sv
`include "room_echo_defines.svh"

package room_echo_pkg;

  localparam int IR_ADDR_W = $clog2(`ROOM_ECHO_IR_TAPS);

  // one audio sample with its single-cycle strobe
  typedef struct packed {
    logic               valid;
    logic signed [15:0] data;
  } audio_sample_t;

  // tap write from the capture block into the convolver bank
  typedef struct packed {
    logic                 en;
    logic [IR_ADDR_W-1:0] addr; // tap index
    logic signed [15:0]   data;
  } ir_write_t;

endpackage

//--- rtl/i2s_mic_rx.sv
`timescale 1ns/1ps
`include "room_echo_defines.svh"

module i2s_mic_rx (
  input  logic                          audio_clk,
  input  logic                          rst_n,
  input  logic                          mic_data,
  output logic                          mic_bclk,
  output logic                          mic_ws,
  output room_echo_pkg::audio_sample_t  sample
);

  localparam int DIV   = `ROOM_ECHO_BCLK_DIV;
  localparam int DIV_W = $clog2(DIV);

  logic [DIV_W-1:0]   div_cnt;
  logic [5:0]         bit_cnt;   // bit clock index within the frame
  logic [5:0]         bit_nxt;
  logic               rise_stb;
  logic               fall_stb;
  logic [15:0]        shreg;
  logic               valid_q;
  logic signed [15:0] data_q;

  assign bit_nxt  = bit_cnt + 6'd1;
  assign rise_stb = (div_cnt == DIV_W'(DIV / 2 - 1)); // bclk goes high next cycle
  assign fall_stb = (div_cnt == DIV_W'(DIV - 1));

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt  <= '0;
      bit_cnt  <= '0;
      mic_bclk <= 1'b0;
      mic_ws   <= 1'b0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      div_cnt <= fall_stb ? '0 : div_cnt + 1'b1;
      if (rise_stb)
        mic_bclk <= 1'b1;
      if (fall_stb) begin
        mic_bclk <= 1'b0;
        bit_cnt  <= bit_nxt;
        mic_ws   <= bit_nxt[5]; // left slot while low
        if (bit_nxt == 6'd32)
          valid_q <= 1'b1;      // right slot starts, word is complete
      end
    end
  end

  // msb arrives one bit clock after ws falls, keep the top 16 of 24 bits
  always_ff @(posedge audio_clk) begin
    if (rise_stb && bit_cnt >= 6'd1 && bit_cnt <= 6'd16)
      shreg <= {shreg[14:0], mic_data};
    if (fall_stb && bit_nxt == 6'd32)
      data_q <= shreg;
  end

  assign sample.valid = valid_q;
  assign sample.data  = data_q;

endmodule

//--- rtl/dc_blocker.sv
`timescale 1ns/1ps
`include "room_echo_defines.svh"

module dc_blocker (
  input  logic                          audio_clk,
  input  logic                          rst_n,
  input  room_echo_pkg::audio_sample_t  din,
  output room_echo_pkg::audio_sample_t  dout
);

  localparam int SH = `ROOM_ECHO_DC_SHIFT;

  logic signed [15:0] x_prev;
  logic signed [15:0] y_prev;
  logic signed [17:0] y_full; // two guard bits
  logic signed [15:0] y_sat;

  // y = x - x1 + y1 - y1/2^SH
  assign y_full = din.data - x_prev + y_prev - (y_prev >>> SH);

  always_comb begin
    if (y_full > 18'sd32767)
      y_sat = 16'sh7fff;
    else if (y_full < -18'sd32768)
      y_sat = 16'sh8000;
    else
      y_sat = y_full[15:0];
  end

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      x_prev     <= '0;
      y_prev     <= '0;
      dout.valid <= 1'b0;
      dout.data  <= '0;
    end else begin
      dout.valid <= din.valid;
      if (din.valid) begin
        x_prev    <= din.data;
        y_prev    <= y_sat;   // saturated value feeds back
        dout.data <= y_sat;
      end
    end
  end

endmodule

//--- rtl/ir_capture.sv
`timescale 1ns/1ps
`include "room_echo_defines.svh"

module ir_capture (
  input  logic                          audio_clk,
  input  logic                          rst_n,
  input  logic                          capture_req,
  input  room_echo_pkg::audio_sample_t  din,
  output logic                          capture_ack,
  output room_echo_pkg::ir_write_t      ir_wr
);

  localparam int TAPS = `ROOM_ECHO_IR_TAPS;
  localparam int AW   = room_echo_pkg::IR_ADDR_W;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_REC  = 2'd1;
  localparam logic [1:0] ST_ACK  = 2'd2;

  logic [1:0]         state;
  logic [AW-1:0]      tap_cnt;
  logic               wr_en;
  logic [AW-1:0]      wr_addr;
  logic signed [15:0] wr_data;
  logic               rec_stb;

  assign rec_stb = (state == ST_REC) && din.valid;

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= ST_IDLE;
      tap_cnt     <= '0;
      wr_en       <= 1'b0;
      capture_ack <= 1'b0;
    end else begin
      wr_en <= rec_stb;
      case (state)
        ST_IDLE: begin
          tap_cnt <= '0;
          if (capture_req)
            state <= ST_REC;
        end
        ST_REC: begin
          if (din.valid) begin
            tap_cnt <= tap_cnt + 1'b1;
            if (tap_cnt == AW'(TAPS - 1))
              state <= ST_ACK; // last tap goes out this cycle
          end
        end
        ST_ACK: begin
          capture_ack <= capture_req; // holds until the host lets go
          if (!capture_req)
            state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge audio_clk) begin
    if (rec_stb) begin
      wr_addr <= tap_cnt;
      wr_data <= din.data;
    end
  end

  assign ir_wr.en   = wr_en;
  assign ir_wr.addr = wr_addr;
  assign ir_wr.data = wr_data;

endmodule

//--- rtl/ir_convolver.sv
`timescale 1ns/1ps
`include "room_echo_defines.svh"

module ir_convolver (
  input  logic                          audio_clk,
  input  logic                          rst_n,
  input  room_echo_pkg::audio_sample_t  din,
  input  room_echo_pkg::ir_write_t      ir_wr,
  output room_echo_pkg::audio_sample_t  dout
);

  localparam int TAPS  = `ROOM_ECHO_IR_TAPS;
  localparam int ACC_W = `ROOM_ECHO_ACC_W;
  localparam int AW    = room_echo_pkg::IR_ADDR_W;

  localparam logic signed [ACC_W-1:0] SAT_MAX = 32767;
  localparam logic signed [ACC_W-1:0] SAT_MIN = -32768;

  logic signed [15:0]      tap_new [TAPS]; // written by capture
  logic signed [15:0]      tap_act [TAPS]; // used by the running sum
  logic signed [15:0]      hist    [TAPS]; // hist[k] = d[n-k]
  logic                    busy;
  logic                    fin;
  logic [AW-1:0]           idx;
  logic signed [31:0]      prod;
  logic signed [ACC_W-1:0] acc;
  logic signed [ACC_W-1:0] acc_sh;
  logic signed [15:0]      wet_sat;

  assign prod   = tap_act[idx] * hist[idx];
  assign acc_sh = acc >>> 15; // taps are q15

  always_comb begin
    if (acc_sh > SAT_MAX)
      wet_sat = 16'sh7fff;
    else if (acc_sh < SAT_MIN)
      wet_sat = 16'sh8000;
    else
      wet_sat = acc_sh[15:0];
  end

  // staging bank, picked up at the next sample
  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < TAPS; i++)
        tap_new[i] <= '0;
    end else if (ir_wr.en) begin
      tap_new[ir_wr.addr] <= ir_wr.data;
    end
  end

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < TAPS; i++) begin
        tap_act[i] <= '0;
        hist[i]    <= '0;
      end
      busy       <= 1'b0;
      fin        <= 1'b0;
      idx        <= '0;
      acc        <= '0;
      dout.valid <= 1'b0;
      dout.data  <= '0;
    end else begin
      fin        <= 1'b0;
      dout.valid <= fin;
      if (fin)
        dout.data <= wet_sat;
      if (din.valid) begin
        hist[0] <= din.data;
        for (int i = TAPS - 1; i > 0; i--)
          hist[i] <= hist[i-1];
        tap_act <= tap_new;
        busy    <= 1'b1;
        idx     <= '0;
        acc     <= '0;
      end else if (busy) begin
        acc <= acc + prod; // one product per cycle
        idx <= idx + 1'b1;
        if (idx == AW'(TAPS - 1)) begin
          busy <= 1'b0;
          fin  <= 1'b1;
        end
      end
    end
  end

endmodule

//--- rtl/pdm_modulator.sv
`timescale 1ns/1ps

module pdm_modulator (
  input  logic                          audio_clk,
  input  logic                          rst_n,
  input  room_echo_pkg::audio_sample_t  level,
  output logic                          pdm
);

  logic [15:0] lvl_u;   // offset binary level
  logic [15:0] acc;
  logic [16:0] sum;

  assign sum = {1'b0, acc} + {1'b0, lvl_u};

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      lvl_u <= 16'h8000; // mid scale
      acc   <= '0;
      pdm   <= 1'b0;
    end else begin
      if (level.valid)
        lvl_u <= {~level.data[15], level.data[14:0]};
      acc <= sum[15:0];
      pdm <= sum[16]; // carry out is the bit stream
    end
  end

endmodule

//--- rtl/room_echo_top.sv
`timescale 1ns/1ps

module room_echo_top (
  input  logic                          audio_clk,
  input  logic                          rst_n,
  input  logic                          mic_data,
  input  logic                          capture_req,
  output logic                          mic_bclk,
  output logic                          mic_ws,
  output logic                          capture_ack,
  output logic                          spk_pdm,
  output room_echo_pkg::audio_sample_t  wet_sample
);

  room_echo_pkg::audio_sample_t raw;
  room_echo_pkg::audio_sample_t dry;
  room_echo_pkg::ir_write_t     ir_wr;

  i2s_mic_rx mic_rx (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .mic_data  (mic_data),
    .mic_bclk  (mic_bclk),
    .mic_ws    (mic_ws),
    .sample    (raw)
  );

  dc_blocker dc_block (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .din       (raw),
    .dout      (dry)
  );

  // records the room response on host request
  ir_capture ir_rec (
    .audio_clk   (audio_clk),
    .rst_n       (rst_n),
    .capture_req (capture_req),
    .din         (dry),
    .capture_ack (capture_ack),
    .ir_wr       (ir_wr)
  );

  ir_convolver conv (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .din       (dry),
    .ir_wr     (ir_wr),
    .dout      (wet_sample)
  );

  pdm_modulator pdm_out (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .level     (wet_sample),
    .pdm       (spk_pdm)
  );

endmodule

//--- tests/room_echo_tb.sv
`timescale 1ns/1ps
`include "room_echo_defines.svh"

module room_echo_tb;

  localparam int TAPS       = `ROOM_ECHO_IR_TAPS;
  localparam int N_FRAMES   = 200;
  localparam int CAP_FRAME  = 20; // frame that carries the capture request
  localparam int MAX_CYCLES = 16 + (N_FRAMES + 20) * 256;
  localparam int WET_LAT    = 1 + TAPS + 2; // ws rise to wet pulse

  logic audio_clk = 1'b0;
  logic rst_n;
  logic mic_data;
  logic capture_req;
  logic mic_bclk;
  logic mic_ws;
  logic capture_ack;
  logic spk_pdm;
  room_echo_pkg::audio_sample_t wet_sample;

  logic [31:0] lfsr = 32'h9be2_8bb4;
  logic [23:0] word;
  int frame_no = 0;
  int bitpos = 0;
  logic bclk_d = 1'b0;
  logic ws_d = 1'b0;
  int x_prev = 0;
  int y_prev = 0;
  int hist [TAPS] = '{default: 0};
  int h [TAPS] = '{default: 0};
  logic signed [15:0] exp_q [$];
  logic bclk_m = 1'b0;
  logic ws_m = 1'b0;
  logic req_m = 1'b0;
  logic ack_m = 1'b0;
  logic wet_m = 1'b0;
  int run = 0;
  int falls = 0;
  int ws_rises = 0;
  int since_ws = 0;
  int ack_late = 0;
  int n_checked = 0;
  int held_level = 0;
  int cycles = 0;

  room_echo_top dut (
    .audio_clk   (audio_clk),
    .rst_n       (rst_n),
    .mic_data    (mic_data),
    .capture_req (capture_req),
    .mic_bclk    (mic_bclk),
    .mic_ws      (mic_ws),
    .capture_ack (capture_ack),
    .spk_pdm     (spk_pdm),
    .wet_sample  (wet_sample)
  );

  always #20 audio_clk = ~audio_clk;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int clamp16(input int v);
    return (v > 32767) ? 32767 : ((v < -32768) ? -32768 : v);
  endfunction

  // pick the next word and run the reference model for its sample
  task automatic start_frame();
    logic in_cap;
    int x;
    int y;
    longint acc;
    in_cap = (frame_no >= CAP_FRAME) && (frame_no < CAP_FRAME + TAPS);
    word = '0;
    if (frame_no == CAP_FRAME)
      capture_req = 1'b1;
    if (!in_cap) begin
      for (int i = 0; i < 24; i++) begin
        word = {word[22:0], lfsr[0]};
        lfsr = lfsr_next(lfsr);
      end
    end else if (frame_no == CAP_FRAME + 2) begin
      word = 24'h40_0000; // single impulse inside the capture window
    end
    x = $signed(word[23:8]);
    y = clamp16(x - x_prev + y_prev - (y_prev >>> `ROOM_ECHO_DC_SHIFT));
    x_prev = x;
    y_prev = y;
    for (int k = TAPS - 1; k > 0; k--)
      hist[k] = hist[k-1];
    hist[0] = y;
    acc = 0;
    for (int k = 0; k < TAPS; k++)
      acc += longint'(h[k]) * hist[k];
    exp_q.push_back(16'(clamp16(int'(acc >>> 15))));
    if (in_cap)
      h[frame_no - CAP_FRAME] = y; // tap is active from the next sample
    frame_no++;
  endtask

  // microphone model, data changes on falling bit clock
  always @(posedge audio_clk) begin
    #2;
    if (bclk_d && !mic_bclk) begin
      bitpos = (ws_d && !mic_ws) ? 0 : bitpos + 1;
      if (!mic_ws && bitpos == 1)
        start_frame();
      mic_data = (!mic_ws && bitpos >= 1 && bitpos <= 24) ? word[24-bitpos] : 1'b0;
    end
    bclk_d = mic_bclk;
    ws_d   = mic_ws;
  end

  always @(negedge audio_clk) begin
    if (!rst_n) begin
      run   = 0;
      falls = 0;
    end else begin
      if (mic_bclk != bclk_m) begin
        assert (run == 2) else fail_now("mic_bclk phase is not 2 cycles long");
        run = 1;
      end else begin
        run++;
      end
      if (bclk_m && !mic_bclk)
        falls++;
      if (mic_ws != ws_m) begin
        assert (bclk_m && !mic_bclk && falls == 32)
          else fail_now("mic_ws toggled off a falling bit clock or after a wrong bit count");
        falls = 0;
      end
      // handshake
      if (capture_req && !req_m)
        ws_rises = 0;
      if (mic_ws && !ws_m)
        ws_rises++;
      if (capture_ack && !ack_m)
        assert (capture_req && ws_rises == 16)
          else fail_now("capture_ack rose without a request or after the wrong frame count");
      if (!capture_ack && ack_m)
        assert (!capture_req) else fail_now("capture_ack fell while capture_req was held");
      ack_late = (capture_ack && !capture_req) ? ack_late + 1 : 0;
      assert (ack_late <= 1) else fail_now("capture_ack stayed high after capture_req fell");
      since_ws = (mic_ws && !ws_m) ? 0 : since_ws + 1;
      if (wet_sample.valid) begin
        assert (!wet_m) else fail_now("wet_sample.valid was high for more than one cycle");
        assert (since_ws == WET_LAT)
          else fail_now($sformatf("MISMATCH wet_sample.valid delay got %h expected %h",
                                  since_ws, WET_LAT));
        assert (exp_q.size() > 0) else fail_now("wet sample arrived with none expected");
        held_level = exp_q.pop_front();
        assert (wet_sample.data == 16'(held_level))
          else fail_now($sformatf("MISMATCH wet_sample.data got %h expected %h",
                                  wet_sample.data, 16'(held_level)));
        n_checked++;
      end
    end
    bclk_m = mic_bclk;
    ws_m   = mic_ws;
    req_m  = capture_req;
    ack_m  = capture_ack;
    wet_m  = wet_sample.valid;
  end

  always @(posedge audio_clk) begin
    cycles++;
    if (cycles > MAX_CYCLES)
      fail_now("timeout, the run did not finish within the cycle limit");
  end

  // ones over the 256 cycles that one wet level is held
  task automatic check_pdm_density();
    int ones;
    int lvl;
    ones = 0;
    @(negedge audio_clk);
    while (!wet_sample.valid)
      @(negedge audio_clk);
    @(negedge audio_clk);
    lvl = held_level;
    repeat (256) begin
      @(negedge audio_clk);
      ones += spk_pdm;
    end
    assert (ones * 256 - (lvl + 32768) <= 512 && (lvl + 32768) - ones * 256 <= 512)
      else fail_now($sformatf("MISMATCH spk_pdm ones got %h expected %h",
                              ones, (lvl + 32768) / 256));
  endtask

  initial begin
    rst_n       = 1'b0;
    mic_data    = 1'b0;
    capture_req = 1'b0;
    repeat (16) @(posedge audio_clk);
    #2 rst_n = 1'b1;
    check_pdm_density(); // zero taps, half density
    while (!capture_ack)
      @(posedge audio_clk);
    #2 capture_req = 1'b0;
    while (capture_ack)
      @(posedge audio_clk);
    repeat (3) check_pdm_density();
    while (n_checked < N_FRAMES)
      @(posedge audio_clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- room_echo.f
+incdir+rtl
rtl/room_echo_pkg.sv
rtl/i2s_mic_rx.sv
rtl/dc_blocker.sv
rtl/ir_capture.sv
rtl/ir_convolver.sv
rtl/pdm_modulator.sv
rtl/room_echo_top.sv
tests/room_echo_tb.sv

//--- Bender.yml
package:
  name: room_echo

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/room_echo_pkg.sv
      - rtl/i2s_mic_rx.sv
      - rtl/dc_blocker.sv
      - rtl/ir_capture.sv
      - rtl/ir_convolver.sv
      - rtl/pdm_modulator.sv
      - rtl/room_echo_top.sv
      - tests/room_echo_tb.sv
